// ==== matmul_engine.f ====
+incdir+logic
logic/mm_pkg.sv
logic/mm_sequencer.sv
logic/mm_mac.sv
logic/mm_result_writer.sv
logic/mm_top.sv
tb/mm_sram_model.sv
tb/tb_mm_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mm_top
FILELIST  ?= matmul_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= RESULT: PASS

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_mm_top.sv ====
/*
 * matrix-multiply engine testbench: backdoor-loaded A and B, start
 * handshake, write tracking and element compare against a reference
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module tb_mm_top import mm_pkg::*; ();

  localparam int CLK_HALF     = 4;     // 8 ns period
  localparam int RESET_CYCLES = 10;
  localparam int WAIT_LIMIT   = 2000;  // cycles per job
  localparam int MAX_ELEMS    = 36;    // 6 x 6
  localparam int FILL_COUNT   = 0;
  localparam int FILL_RANDOM  = 1;
  localparam int FILL_HIGH    = 2;

  logic                  clk;
  logic                  reset_n;
  logic                  dut_valid;
  logic                  dut_ready;
  logic [`MM_ADDR_W-1:0] input_rd_addr;
  logic [`MM_DATA_W-1:0] input_rd_data;
  logic [`MM_ADDR_W-1:0] weight_rd_addr;
  logic [`MM_DATA_W-1:0] weight_rd_data;
  mm_sram_wr_t           result_wr;

  logic [`MM_DATA_W-1:0] a_mat [MAX_ELEMS];
  logic [`MM_DATA_W-1:0] b_mat [MAX_ELEMS];
  bit                    written [MAX_ELEMS];
  int                    cur_m;
  int                    cur_k;
  int                    cur_n;
  logic [31:0]           seed;
  int                    error_count;
  int                    job_count;
  bit                    timed_out;

  mm_top i_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd_addr  (input_rd_addr),
    .input_rd_data  (input_rd_data),
    .weight_rd_addr (weight_rd_addr),
    .weight_rd_data (weight_rd_data),
    .result_wr      (result_wr)
  );

  mm_sram_model i_input_mem (
    .clk (clk), .rd_addr (input_rd_addr), .rd_data (input_rd_data),
    .wr_en (1'b0), .wr_addr ('0), .wr_data ('0)
  );

  mm_sram_model i_weight_mem (
    .clk (clk), .rd_addr (weight_rd_addr), .rd_data (weight_rd_data),
    .wr_en (1'b0), .wr_addr ('0), .wr_data ('0)
  );

  // read back through the backdoor only
  mm_sram_model i_result_mem (
    .clk (clk), .rd_addr ('0), .rd_data (),
    .wr_en (result_wr.en), .wr_addr (result_wr.addr), .wr_data (result_wr.data)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // --------------------
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // C[i][j] = sum over k of A[i][k] * B[k][j], low 32 bits kept
  function automatic logic [31:0] expected_element(input int i, input int j);
    logic [63:0] total;
    total = '0;
    for (int k = 0; k < cur_k; k++) begin
      total = total + 64'(a_mat[i * cur_k + k]) * 64'(b_mat[k * cur_n + j]);
    end
    return total[31:0];
  endfunction

  function automatic logic [31:0] pick_operand(input int mode, input int idx, input bit is_b);
    case (mode)
      FILL_RANDOM: begin
        seed = lcg_next(seed);
        return seed ^ (seed >> 13);
      end
      FILL_HIGH: return (is_b ? 32'h8000_0005 : 32'h7fff_fffb) + 32'(idx);  // near 2^31
      default:   return 32'(idx + 1) + (is_b ? 32'd10 : 32'd0);
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic load_matrices(input int mode);
    i_input_mem.load_word(`MM_ADDR_W'(`MM_HEADER_ADDR), {16'(cur_m), 16'(cur_k)});
    i_weight_mem.load_word(`MM_ADDR_W'(`MM_HEADER_ADDR), {16'(cur_k), 16'(cur_n)});
    for (int idx = 0; idx < cur_m * cur_k; idx++) begin
      a_mat[idx] = pick_operand(mode, idx, 1'b0);
      i_input_mem.load_word(`MM_ADDR_W'(`MM_DATA_BASE + idx), a_mat[idx]);
    end
    for (int idx = 0; idx < cur_k * cur_n; idx++) begin
      b_mat[idx] = pick_operand(mode, idx, 1'b1);
      i_weight_mem.load_word(`MM_ADDR_W'(`MM_DATA_BASE + idx), b_mat[idx]);
    end
  endtask

  // --------------------
  // one job: load, start, track writes until ready, compare C

  task automatic run_job(input int m, input int k, input int n, input int mode);
    int  cycles;
    int  wr_count;
    int  addr;
    bit  done;
    if (timed_out) return;
    cur_m = m;
    cur_k = k;
    cur_n = n;
    load_matrices(mode);
    for (int e = 0; e < MAX_ELEMS; e++) begin
      written[e] = 1'b0;
    end
    @(posedge clk);
    dut_valid <= 1'b1;
    @(posedge clk);            // handshake edge, ready still high
    dut_valid <= 1'b0;
    wr_count = 0;
    cycles   = 0;
    done     = 1'b0;
    while (!done && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (result_wr.en) begin
        addr = int'(result_wr.addr);
        wr_count++;
        if (addr >= m * n) begin
          report_error($sformatf("write to address %0d beyond the %0d elements of C",
                                 addr, m * n));
        end else if (written[addr]) begin
          report_error($sformatf("result address %0d written more than once", addr));
        end else begin
          written[addr] = 1'b1;
        end
      end
      if (dut_ready) done = 1'b1;  // early rise shows as a short write count
    end
    if (!done) begin
      report_error($sformatf("dut_ready did not return within %0d cycles of a %0dx%0dx%0d job",
                             WAIT_LIMIT, m, k, n));
      timed_out = 1'b1;
      return;
    end
    check_value("result write count", 32'(wr_count), 32'(m * n));
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < n; j++) begin
        check_value($sformatf("C[%0d][%0d] at result address %0d", i, j, i * n + j),
                    i_result_mem.read_word(`MM_ADDR_W'(i * n + j)), expected_element(i, j));
      end
    end
    job_count++;
  endtask

  // --------------------
  // main sequence

  initial begin
    int m;
    int k;
    int n;
    reset_n     = 1'b0;
    dut_valid   = 1'b0;
    seed        = 32'd45;
    error_count = 0;
    job_count   = 0;
    timed_out   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;

    // idle after reset: ready up, nothing written
    repeat (4) begin
      @(negedge clk);
      check_value("dut_ready", 32'(dut_ready), 32'd1);
      check_value("result_wr.en", 32'(result_wr.en), 32'd0);
    end

    run_job(2, 3, 2, FILL_COUNT);
    for (int job = 0; job < 8; job++) begin
      seed = lcg_next(seed);
      m = 1 + int'((seed >> 16) % 32'd6);
      seed = lcg_next(seed);
      k = 1 + int'((seed >> 16) % 32'd6);
      seed = lcg_next(seed);
      n = 1 + int'((seed >> 16) % 32'd6);
      run_job(m, k, n, FILL_RANDOM);
    end
    run_job(1, 1, 1, FILL_RANDOM);
    run_job(1, 6, 1, FILL_RANDOM);   // longest single dot product
    run_job(2, 4, 2, FILL_HIGH);

    $display("tb_mm_top: %0d jobs completed, %0d errors", job_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/mm_sram_model.sv ====
/*
 * behavioral SRAM, one read and one write port, read data one cycle
 * after the address, plus backdoor load and peek for the testbench
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module mm_sram_model (
  input  logic                  clk,
  input  logic [`MM_ADDR_W-1:0] rd_addr,
  output logic [`MM_DATA_W-1:0] rd_data,
  input  logic                  wr_en,
  input  logic [`MM_ADDR_W-1:0] wr_addr,
  input  logic [`MM_DATA_W-1:0] wr_data
);

  localparam int unsigned DEPTH = 1 << `MM_ADDR_W;

  logic [`MM_DATA_W-1:0] mem [DEPTH];

  // address-tagged fill, so a missed write shows up as a wrong value
  initial begin
    for (int unsigned a = 0; a < DEPTH; a++) begin
      mem[a] = 32'hdead_0000 | 32'(a);
    end
  end

  // write first, then read
  always @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] = wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  // --------------------
  // backdoor

  task automatic load_word(input logic [`MM_ADDR_W-1:0] addr,
                           input logic [`MM_DATA_W-1:0] data);
    mem[addr] = data;
  endtask

  function automatic logic [`MM_DATA_W-1:0] read_word(input logic [`MM_ADDR_W-1:0] addr);
    return mem[addr];
  endfunction

endmodule

`default_nettype wire

// ==== logic/mm_top.sv ====
/*
 * matrix-multiply engine top: sequencer -> MAC -> result writer,
 * connected to the input, weight and result SRAM ports
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module mm_top import mm_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,

  // start handshake
  input  logic                  dut_valid,
  output logic                  dut_ready,

  // input SRAM, matrix A
  output logic [`MM_ADDR_W-1:0] input_rd_addr,
  input  logic [`MM_DATA_W-1:0] input_rd_data,

  // weight SRAM, matrix B
  output logic [`MM_ADDR_W-1:0] weight_rd_addr,
  input  logic [`MM_DATA_W-1:0] weight_rd_data,

  // result SRAM, matrix C
  output mm_sram_wr_t           result_wr
);

  mm_operand_tag_t operand_tag;  // sequencer to MAC
  mm_result_t      result;       // MAC to writer
  logic            job_done;     // writer back to sequencer

  mm_sequencer i_sequencer (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .input_rd_addr  (input_rd_addr),
    .weight_rd_addr (weight_rd_addr),
    .operand_tag    (operand_tag),
    .job_done       (job_done)
  );

  // operands come straight off the SRAM read ports
  mm_mac i_mac (
    .clk         (clk),
    .reset_n     (reset_n),
    .a_data      (input_rd_data),
    .b_data      (weight_rd_data),
    .operand_tag (operand_tag),
    .result      (result)
  );

  mm_result_writer i_writer (
    .clk       (clk),
    .reset_n   (reset_n),
    .result    (result),
    .result_wr (result_wr),
    .job_done  (job_done)
  );

endmodule

`default_nettype wire

// ==== logic/mm_result_writer.sv ====
/*
 * result writer: row-major write addressing into the result SRAM
 * and end-of-job pulse back to the sequencer
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module mm_result_writer import mm_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  mm_result_t  result,
  output mm_sram_wr_t result_wr,
  output logic        job_done
);

  localparam logic [`MM_ADDR_W-1:0] ADDR_ONE = `MM_ADDR_W'(1);

  logic [`MM_ADDR_W-1:0] wr_addr;  // next C element

  // --------------------
  // address counter

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_addr <= '0;
    end else if (result.valid) begin
      if (result.last_all) begin
        wr_addr <= '0;  // ready for the next job
      end else begin
        wr_addr <= wr_addr + ADDR_ONE;
      end
    end
  end

  // --------------------
  // write port, same cycle as the result

  assign result_wr = '{en: result.valid, addr: wr_addr, data: result.data};
  assign job_done  = result.valid && result.last_all;

  // a new job needs a fresh handshake, so nothing follows the last result
  a_no_result_after_done: assert property (@(posedge clk) disable iff (!reset_n)
    job_done |=> !result.valid)
    else $error("result arrived right after the end of a job");

endmodule

`default_nettype wire

// ==== logic/mm_mac.sv ====
/*
 * multiply-accumulate lane, one operand pair per cycle,
 * emits each finished dot product with 32-bit wrap-around
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module mm_mac import mm_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [`MM_DATA_W-1:0] a_data,
  input  logic [`MM_DATA_W-1:0] b_data,
  input  mm_operand_tag_t       operand_tag,
  output mm_result_t            result
);

  logic [`MM_DATA_W-1:0] product;
  logic [`MM_DATA_W-1:0] sum;
  logic [`MM_DATA_W-1:0] acc;
  logic [`MM_DATA_W-1:0] res_data;
  logic                  res_valid;
  logic                  res_last;

  assign product = a_data * b_data;  // low word only
  assign sum     = acc + product;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      acc       <= '0;
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else begin
      res_valid <= operand_tag.valid && operand_tag.last_k;
      res_last  <= operand_tag.valid && operand_tag.last_all;
      if (operand_tag.valid) begin
        acc <= operand_tag.last_k ? '0 : sum;  // restart for the next element
      end
    end
  end

  always_ff @(posedge clk) begin
    if (operand_tag.valid && operand_tag.last_k) begin
      res_data <= sum;
    end
  end

  assign result = '{valid: res_valid, last_all: res_last, data: res_data};

  // markers from the sequencer only ride on real operand pairs
  a_marks_valid: assert property (@(posedge clk) disable iff (!reset_n)
    (operand_tag.last_k || operand_tag.last_all) |-> operand_tag.valid)
    else $error("last marker on an invalid operand tag");

endmodule

`default_nettype wire

// ==== logic/mm_sequencer.sv ====
/*
 * matmul sequencer: start handshake, header capture, i/j/k loop
 * counters and row-major read addressing of A and B
 */
`timescale 1ns/1ps
`default_nettype none
`include "mm_defs.svh"

module mm_sequencer import mm_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  dut_valid,
  output logic                  dut_ready,
  input  logic [`MM_DATA_W-1:0] input_rd_data,   // header word only
  input  logic [`MM_DATA_W-1:0] weight_rd_data,  // header word only
  output logic [`MM_ADDR_W-1:0] input_rd_addr,
  output logic [`MM_ADDR_W-1:0] weight_rd_addr,
  output mm_operand_tag_t       operand_tag,
  input  logic                  job_done
);

  localparam int unsigned LIN_W = 2 * `MM_DIM_W;  // wide enough for any i*K+k

  localparam logic [`MM_ADDR_W-1:0] HEADER_ADDR = `MM_ADDR_W'(`MM_HEADER_ADDR);
  localparam logic [`MM_ADDR_W-1:0] DATA_BASE   = `MM_ADDR_W'(`MM_DATA_BASE);
  localparam logic [`MM_DIM_W-1:0]  DIM_ONE     = `MM_DIM_W'(1);

  mm_state_e state;
  mm_state_e state_nxt;

  mm_dims_t dims_a;  // M x K
  mm_dims_t dims_b;  // K x N

  logic [`MM_DIM_W-1:0] cnt_i;
  logic [`MM_DIM_W-1:0] cnt_j;
  logic [`MM_DIM_W-1:0] cnt_k;

  logic             streaming;
  logic             k_last;
  logic             j_last;
  logic             i_last;
  logic             all_last;
  logic [LIN_W-1:0] a_lin;
  logic [LIN_W-1:0] b_lin;
  logic [LIN_W-1:0] a_size;
  logic [LIN_W-1:0] b_size;

  // --------------------
  // control FSM

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (dut_valid && dut_ready) state_nxt = LOAD_DIMS;
      LOAD_DIMS: state_nxt = STREAM;           // header data is on the bus now
      STREAM:    if (all_last) state_nxt = DRAIN;
      DRAIN:     if (job_done) state_nxt = DONE;
      DONE:      state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign dut_ready = (state == IDLE);
  assign streaming = (state == STREAM);

  // header words arrive one cycle after address 0 was presented
  always_ff @(posedge clk) begin
    if (state == LOAD_DIMS) begin
      dims_a <= input_rd_data;
      dims_b <= weight_rd_data;
    end
  end

  // --------------------
  // loop counters, k fastest

  assign k_last   = (cnt_k == dims_a.cols - DIM_ONE);
  assign j_last   = (cnt_j == dims_b.cols - DIM_ONE);
  assign i_last   = (cnt_i == dims_a.rows - DIM_ONE);
  assign all_last = k_last && j_last && i_last;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cnt_i <= '0;
      cnt_j <= '0;
      cnt_k <= '0;
    end else if (state == LOAD_DIMS) begin
      cnt_i <= '0;
      cnt_j <= '0;
      cnt_k <= '0;
    end else if (streaming) begin
      if (!k_last) begin
        cnt_k <= cnt_k + DIM_ONE;
      end else begin
        cnt_k <= '0;
        if (!j_last) begin
          cnt_j <= cnt_j + DIM_ONE;
        end else begin
          cnt_j <= '0;
          cnt_i <= cnt_i + DIM_ONE;  // next output row
        end
      end
    end
  end

  // --------------------
  // read addresses

  assign a_lin = LIN_W'(cnt_i) * LIN_W'(dims_a.cols) + LIN_W'(cnt_k);  // i*K + k
  assign b_lin = LIN_W'(cnt_k) * LIN_W'(dims_b.cols) + LIN_W'(cnt_j);  // k*N + j

  assign input_rd_addr  = streaming ? DATA_BASE + a_lin[`MM_ADDR_W-1:0] : HEADER_ADDR;
  assign weight_rd_addr = streaming ? DATA_BASE + b_lin[`MM_ADDR_W-1:0] : HEADER_ADDR;

  // tag follows the address by one cycle, same as the SRAM data
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      operand_tag <= '0;
    end else begin
      operand_tag <= '{valid:    streaming,
                       last_k:   streaming && k_last,
                       last_all: streaming && all_last};
    end
  end

  // --------------------
  // checks

  assign a_size = LIN_W'(dims_a.rows) * LIN_W'(dims_a.cols);
  assign b_size = LIN_W'(dims_a.cols) * LIN_W'(dims_b.cols);  // K taken from A

  a_rd_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    streaming |-> (LIN_W'(input_rd_addr) < LIN_W'(DATA_BASE) + a_size) &&
                  (LIN_W'(weight_rd_addr) < LIN_W'(DATA_BASE) + b_size))
    else $error("read address beyond the last operand");

  // ready comes back only through DONE, two cycles after the last write
  a_ready_after_done: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(dut_ready) |-> $past(job_done, 2))
    else $error("dut_ready rose without a finished job");

endmodule

`default_nettype wire

// ==== logic/mm_pkg.sv ====
/*
 * matrix-multiply engine types
 * states and the structs passed between sequencer, MAC and writer
 */
`default_nettype none
`include "mm_defs.svh"

package mm_pkg;

  // sequencer FSM
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD_DIMS = 3'd1,
    STREAM    = 3'd2,
    DRAIN     = 3'd3,
    DONE      = 3'd4
  } mm_state_e;

  // same layout as the header word at address 0
  typedef struct packed {
    logic [`MM_DIM_W-1:0] rows;
    logic [`MM_DIM_W-1:0] cols;
  } mm_dims_t;

  // travels with each operand pair
  typedef struct packed {
    logic valid;
    logic last_k;    // final product of one dot product
    logic last_all;  // final product of the job
  } mm_operand_tag_t;

  // one finished output element
  typedef struct packed {
    logic                 valid;
    logic                 last_all;
    logic [`MM_DATA_W-1:0] data;
  } mm_result_t;

  // result SRAM write port
  typedef struct packed {
    logic                 en;
    logic [`MM_ADDR_W-1:0] addr;
    logic [`MM_DATA_W-1:0] data;
  } mm_sram_wr_t;

endpackage

`default_nettype wire

// ==== logic/mm_defs.svh ====
/*
 * matrix-multiply engine widths and fixed SRAM addresses
 */
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// --------------------
// widths
`define MM_ADDR_W 12    // SRAM address bits
`define MM_DATA_W 32    // SRAM word and accumulator bits
`define MM_DIM_W  16    // one dimension field of the header word

// --------------------
// memory layout
`define MM_HEADER_ADDR 0  // rows in [31:16], cols in [15:0]
`define MM_DATA_BASE   1  // first element, row-major

`endif
